// File: bench/execUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module execUnitTb;
	import tpuPkg::*;

	localparam int NUM_CMDS    = 400;
	localparam int CYCLE_LIMIT = NUM_CMDS * 8;  // Worst case per command
	localparam int MEM_WORDS   = 256;
	localparam int MEM_SPAN    = 64;            // Small span so loads hit stores

	typedef struct packed {
		logic             write;
		logic [DST_W-1:0] dst;
		data_t            data;
		issueNo_t         issueNo;
	} expectS;

	logic clock, arstN, cmdValid, cmdReady, rsltValid, rsltWrite;
	logic memCyc, memStb, memWe, memAck;
	logic [15:0] cmdInstr;
	data_t cmdData1, cmdData2, rsltData, memAdr, memDatW, memDatR, heldAdr;
	logic [DST_W-1:0] rsltDst;
	issueNo_t rsltIssueNo;

	data_t memArray  [MEM_WORDS];               // Bus model storage
	data_t shadowMem [MEM_WORDS];               // Reference copy in issue order
	expectS expQ [$];
	int acceptCnt, resultCnt, cycleCnt, waitLeft;
	bit started, inAccess, pending;

	execUnit u_execUnit (.*);

	always #10 clock = ~clock;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkEq(input string name, input data_t expV, input data_t actV);
		if (expV !== actV) begin
			failRun($sformatf("error at %0t: %s expected %h got %h", $time, name, expV, actV));
		end
	endtask

	function automatic data_t memAddress(input logic [15:0] instr, input data_t d1);
		return d1 + {{(DATA_W-OFFSET_W){instr[8]}}, instr[8:0]};
	endfunction

	// Expected write-back, decoded straight from the instruction bits
	function automatic expectS refResult(input logic [15:0] instr, input data_t d1,
		input data_t d2, input issueNo_t no);
		expectS e;
		data_t  opB;
		data_t  addr;
		opB       = instr[0] ? {24'h0, instr[8:1]} : d2;
		addr      = memAddress(instr, d1);
		e.write   = 1'b1;
		e.dst     = instr[12:9];
		e.issueNo = no;
		case (instr[15:13])
			3'd0:    e.data = d1 + opB;
			3'd1:    e.data = d1 - opB;
			3'd2:    e.data = d1 * opB;
			3'd3:    e.data = opB;
			3'd4:    e.data = shadowMem[addr[9:2]];
			default: begin
				e.data  = '0;
				e.write = 1'b0;                     // Store frees slot only
			end
		endcase
		return e;
	endfunction

	task automatic makeCommand(output logic [15:0] instr, output data_t d1, output data_t d2);
		logic [2:0]          op;
		logic [3:0]          dst;
		logic [OFFSET_W-1:0] off;
		data_t               idx;
		op  = 3'($urandom % 6);
		dst = 4'($urandom);
		d2  = $urandom;
		if (op >= 3'd4) begin
			idx   = $urandom % MEM_SPAN;
			off   = 9'($urandom);
			d1    = (idx * 4) - {{(DATA_W-OFFSET_W){off[8]}}, off};  // Lands on word idx
			instr = {op, dst, off};
		end else begin
			d1    = $urandom;
			instr = {op, dst, 8'($urandom), 1'($urandom)};
		end
	endtask

	initial begin
		void'($urandom(32'h157adfa7));
		for (int i = 0; i < MEM_WORDS; i++) begin
			memArray[i]  = 32'h5a000000 ^ (i * 32'h00010203);
			shadowMem[i] = memArray[i];
		end
		clock    = 1'b0;
		arstN    = 1'b0;
		cmdValid = 1'b0;
		cmdInstr = '0;
		cmdData1 = '0;
		cmdData2 = '0;
		memDatR  = '0;
		memAck   = 1'b0;
		repeat (3) @(posedge clock);
		arstN <= 1'b1;
	end

	////////////////////////////////
	// Stimulus and expected queue
	////////////////////////////////
	always @(posedge clock) begin
		logic [15:0] instr;
		data_t       d1;
		data_t       d2;
		data_t       addr;
		if (arstN) begin
			if (!started) begin
				checkEq("cmdReady", 32'(1), 32'(cmdReady));
				checkEq("rsltValid", 32'(0), 32'(rsltValid));
				checkEq("memCyc", 32'(0), 32'(memCyc));
				checkEq("memWe", 32'(0), 32'(memWe));
				started = 1'b1;
			end
			if (cmdValid && cmdReady) begin
				expQ.push_back(refResult(cmdInstr, cmdData1, cmdData2, issueNo_t'(acceptCnt)));
				addr = memAddress(cmdInstr, cmdData1);
				if (cmdInstr[15:13] == 3'd5) begin
					shadowMem[addr[9:2]] = cmdData2;
				end
				acceptCnt++;
			end
			// Command is held unchanged while stalled
			if (!cmdValid || cmdReady) begin
				if (acceptCnt < NUM_CMDS && ($urandom % 8) != 0) begin
					makeCommand(instr, d1, d2);
					cmdValid <= 1'b1;
					cmdInstr <= instr;
					cmdData1 <= d1;
					cmdData2 <= d2;
				end else begin
					cmdValid <= 1'b0;
				end
			end
		end
	end

	// Wishbone slave with 0 to 3 wait cycles
	always @(posedge clock) begin
		if (memStb && !memAck) begin
			if (!pending) begin
				pending  = 1'b1;
				waitLeft = $urandom % 4;
			end
			if (waitLeft == 0) begin
				memAck  <= 1'b1;
				memDatR <= memArray[memAdr[9:2]];
				if (memWe) begin
					memArray[memAdr[9:2]] = memDatW;
				end
				pending = 1'b0;
			end else begin
				waitLeft--;
			end
		end else begin
			memAck <= 1'b0;
		end
	end

	////////////////////////////////
	// Checking
	////////////////////////////////
	always @(posedge clock) begin
		expectS e;
		if (arstN && rsltValid) begin
			if (expQ.size() == 0) begin
				failRun("a result arrived with no command outstanding");
			end else begin
				e = expQ.pop_front();
				checkEq("rsltIssueNo", 32'(e.issueNo), 32'(rsltIssueNo));
				checkEq("rsltWrite", 32'(e.write), 32'(rsltWrite));
				if (e.write) begin
					checkEq("rsltDst", 32'(e.dst), 32'(rsltDst));
					checkEq("rsltData", e.data, rsltData);
				end
				resultCnt++;
			end
		end
	end

	always @(posedge clock) begin
		if (arstN) begin
			checkEq("memStb", 32'(memCyc), 32'(memStb));
			if (memCyc) begin
				if (inAccess) begin
					checkEq("memAdr", heldAdr, memAdr);   // Held until ack
				end else begin
					heldAdr = memAdr;
				end
				inAccess = !memAck;
			end else begin
				inAccess = 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycleCnt++;
		if (acceptCnt == NUM_CMDS && resultCnt == NUM_CMDS && expQ.size() == 0) begin
			$display("PASS: all tests");
			$finish;
		end else if (cycleCnt >= CYCLE_LIMIT) begin
			failRun($sformatf("timeout: %0d commands taken, %0d results seen after %0d cycles",
				acceptCnt, resultCnt, cycleCnt));
		end
	end

endmodule

`default_nettype wire

// File: execUnit.f
src/tpuPkg.sv
src/execIfs.sv
src/execDecode.sv
src/mathPipe.sv
src/loadStoreUnit.sv
src/resultReorder.sv
src/execUnit.sv
bench/execUnitTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execUnit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f execUnit.f \
	--top-module execUnitTb \
	-o simExecUnit

./obj_dir/simExecUnit

// File: src/execDecode.sv
`timescale 1ns/100ps
`default_nettype none

module execDecode (
	input  wire logic              clock,
	input  wire logic              arstN,
	input  wire logic              cmdValid,
	input  wire tpuPkg::instrWordU cmdInstr,
	input  wire tpuPkg::data_t     cmdData1,
	input  wire tpuPkg::data_t     cmdData2,
	input  wire logic              robFull,
	input  wire logic              lsuBusy,
	output logic                   cmdReady,
	issueIf.issuer                 issue
);
	import tpuPkg::*;

	pathE     cmdPath;
	logic     cmdTake;
	issueNo_t issueCnt;
	data_t    memAddr;
	data_t    aluOpB;

	always_comb begin
		case (cmdInstr.aluFmt.opcode)
			ADD, SUB, MUL: cmdPath = PATH_MATH;
			LOAD, STORE:   cmdPath = PATH_MEM;
			default:       cmdPath = PATH_MOVE;    // MOV and spare codes
		endcase
	end

	// Same word read two ways
	assign memAddr = cmdData1 + {{(DATA_W-OFFSET_W){cmdInstr.memFmt.offset[OFFSET_W-1]}},
		cmdInstr.memFmt.offset};
	assign aluOpB  = cmdInstr.aluFmt.useImm ? {{(DATA_W-IMM_W){1'b0}}, cmdInstr.aluFmt.imm}
		: cmdData2;

	assign cmdReady = !robFull && !(cmdPath == PATH_MEM && lsuBusy);
	assign cmdTake  = cmdValid && cmdReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			issue.valid <= 1'b0;
			issueCnt    <= '0;
		end else begin
			issue.valid <= cmdTake;
			if (cmdTake) begin
				issueCnt <= issueCnt + issueNo_t'(1);   // Numbers wrap
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cmdTake) begin
			issue.path      <= cmdPath;
			issue.op        <= cmdInstr.aluFmt.opcode;
			issue.issueNo   <= issueCnt;
			issue.dst       <= cmdInstr.aluFmt.dst;
			issue.opA       <= (cmdPath == PATH_MEM) ? memAddr : cmdData1;
			issue.opB       <= aluOpB;
			issue.storeData <= cmdData2;
		end
	end

endmodule

`default_nettype wire

// File: src/execIfs.sv
`timescale 1ns/100ps
`default_nettype none

interface issueIf;
	import tpuPkg::*;

	logic             valid;
	pathE             path;                         // Exactly one taker acts
	opcodeE           op;
	issueNo_t         issueNo;
	logic [DST_W-1:0] dst;
	data_t            opA;                          // Byte address on the memory path
	data_t            opB;
	data_t            storeData;

	modport issuer (output valid, path, op, issueNo, dst, opA, opB, storeData);
	modport taker  (input valid, path, op, issueNo, dst, opA, opB, storeData);

endinterface

interface resultIf;
	import tpuPkg::*;

	logic             valid;                        // One-cycle pulse, always accepted
	issueNo_t         issueNo;
	logic [DST_W-1:0] dst;
	data_t            data;
	logic             write;                        // Low for a store

	modport producer  (output valid, issueNo, dst, data, write);
	modport collector (input valid, issueNo, dst, data, write);

endinterface

`default_nettype wire

// File: src/execUnit.sv
`timescale 1ns/100ps
`default_nettype none

module execUnit (
	input  wire logic                clock,
	input  wire logic                arstN,
	input  wire logic                cmdValid,
	input  wire logic [15:0]         cmdInstr,
	input  wire tpuPkg::data_t       cmdData1,
	input  wire tpuPkg::data_t       cmdData2,
	output logic                     cmdReady,
	output logic                     rsltValid,
	output logic                     rsltWrite,
	output logic [tpuPkg::DST_W-1:0] rsltDst,
	output tpuPkg::data_t            rsltData,
	output tpuPkg::issueNo_t         rsltIssueNo,
	output logic                     memCyc,
	output logic                     memStb,
	output logic                     memWe,
	output tpuPkg::data_t            memAdr,
	output tpuPkg::data_t            memDatW,
	input  wire tpuPkg::data_t       memDatR,
	input  wire logic                memAck
);

	logic robFull;
	logic lsuBusy;

	issueIf  issueBus ();
	resultIf mathResBus ();
	resultIf memResBus ();

	execDecode u_execDecode (
		.clock    (clock),
		.arstN    (arstN),
		.cmdValid (cmdValid),
		.cmdInstr (cmdInstr),
		.cmdData1 (cmdData1),
		.cmdData2 (cmdData2),
		.robFull  (robFull),
		.lsuBusy  (lsuBusy),
		.cmdReady (cmdReady),
		.issue    (issueBus.issuer)
	);

	mathPipe u_mathPipe (
		.clock  (clock),
		.arstN  (arstN),
		.issue  (issueBus.taker),
		.result (mathResBus.producer)
	);

	loadStoreUnit u_loadStoreUnit (
		.clock   (clock),
		.arstN   (arstN),
		.memDatR (memDatR),
		.memAck  (memAck),
		.lsuBusy (lsuBusy),
		.memCyc  (memCyc),
		.memStb  (memStb),
		.memWe   (memWe),
		.memAdr  (memAdr),
		.memDatW (memDatW),
		.issue   (issueBus.taker),
		.result  (memResBus.producer)
	);

	// Move path goes straight into the reorder buffer
	resultReorder u_resultReorder (
		.clock       (clock),
		.arstN       (arstN),
		.robFull     (robFull),
		.rsltValid   (rsltValid),
		.rsltWrite   (rsltWrite),
		.rsltDst     (rsltDst),
		.rsltData    (rsltData),
		.rsltIssueNo (rsltIssueNo),
		.issue       (issueBus.taker),
		.mathRes     (mathResBus.collector),
		.memRes      (memResBus.collector)
	);

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit (
	input  wire logic            clock,
	input  wire logic            arstN,
	input  wire tpuPkg::data_t   memDatR,
	input  wire logic            memAck,
	output logic                 lsuBusy,
	output logic                 memCyc,
	output logic                 memStb,
	output logic                 memWe,
	output tpuPkg::data_t        memAdr,
	output tpuPkg::data_t        memDatW,
	issueIf.taker                issue,
	resultIf.producer            result
);
	import tpuPkg::*;

	typedef enum logic {IDLE, ACCESS} lsuStateE;

	lsuStateE         state;
	logic             take;
	logic             resValid;
	logic [DST_W-1:0] accDst;
	issueNo_t         accIssue;
	data_t            loadData;

	assign take = issue.valid && issue.path == PATH_MEM;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state    <= IDLE;
			resValid <= 1'b0;
			memWe    <= 1'b0;
		end else begin
			resValid <= 1'b0;
			case (state)
				IDLE: begin
					if (take) begin
						state <= ACCESS;
						memWe <= (issue.op == STORE);     // Held until next access
					end
				end
				ACCESS: begin
					if (memAck) begin
						state    <= IDLE;
						resValid <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && take) begin
			memAdr   <= issue.opA;
			memDatW  <= issue.storeData;
			accDst   <= issue.dst;
			accIssue <= issue.issueNo;
		end
		if (state == ACCESS && memAck) begin
			loadData <= memDatR;
		end
	end

	assign memCyc  = (state == ACCESS);
	assign memStb  = memCyc;                        // Classic cycle, no pipelining
	assign lsuBusy = take || memCyc || resValid;

	assign result.valid   = resValid;
	assign result.issueNo = accIssue;
	assign result.dst     = accDst;
	assign result.data    = loadData;
	assign result.write   = !memWe;

endmodule

`default_nettype wire

// File: src/mathPipe.sv
`timescale 1ns/100ps
`default_nettype none

module mathPipe (
	input  wire logic clock,
	input  wire logic arstN,
	issueIf.taker     issue,
	resultIf.producer result
);
	import tpuPkg::*;

	logic             stValid [MATH_DEPTH];
	data_t            stValue [MATH_DEPTH];
	logic [DST_W-1:0] stDst   [MATH_DEPTH];
	issueNo_t         stIssue [MATH_DEPTH];
	logic             take;
	data_t            calc;

	assign take = issue.valid && issue.path == PATH_MATH;

	// First stage does the arithmetic
	always_comb begin
		case (issue.op)
			SUB:     calc = issue.opA - issue.opB;
			MUL:     calc = issue.opA * issue.opB;   // Low word of product
			default: calc = issue.opA + issue.opB;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < MATH_DEPTH; i++) begin
				stValid[i] <= 1'b0;
			end
		end else begin
			stValid[0] <= take;
			for (int i = 1; i < MATH_DEPTH; i++) begin
				stValid[i] <= stValid[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		stValue[0] <= calc;
		stDst[0]   <= issue.dst;
		stIssue[0] <= issue.issueNo;
		for (int i = 1; i < MATH_DEPTH; i++) begin
			stValue[i] <= stValue[i-1];             // Delay stages
			stDst[i]   <= stDst[i-1];
			stIssue[i] <= stIssue[i-1];
		end
	end

	assign result.valid   = stValid[MATH_DEPTH-1];
	assign result.issueNo = stIssue[MATH_DEPTH-1];
	assign result.dst     = stDst[MATH_DEPTH-1];
	assign result.data    = stValue[MATH_DEPTH-1];
	assign result.write   = 1'b1;

endmodule

`default_nettype wire

// File: src/resultReorder.sv
`timescale 1ns/100ps
`default_nettype none

module resultReorder (
	input  wire logic                clock,
	input  wire logic                arstN,
	output logic                     robFull,
	output logic                     rsltValid,
	output logic                     rsltWrite,
	output logic [tpuPkg::DST_W-1:0] rsltDst,
	output tpuPkg::data_t            rsltData,
	output tpuPkg::issueNo_t         rsltIssueNo,
	issueIf.taker                    issue,
	resultIf.collector               mathRes,
	resultIf.collector               memRes
);
	import tpuPkg::*;

	logic                 entFilled [ROB_DEPTH];
	logic                 entWrite  [ROB_DEPTH];
	logic [DST_W-1:0]     entDst    [ROB_DEPTH];
	data_t                entData   [ROB_DEPTH];
	issueNo_t             tailNo;                   // Oldest outstanding command
	logic [ROB_CNT_W-1:0] occupancy;
	logic [ROB_IDX_W-1:0] allocIdx;
	logic [ROB_IDX_W-1:0] mathIdx;
	logic [ROB_IDX_W-1:0] memIdx;
	logic [ROB_IDX_W-1:0] tailIdx;
	logic                 isMove;
	logic                 doRelease;

	// Low issue bits are unique while at most ROB_DEPTH are in flight
	assign allocIdx  = issue.issueNo[ROB_IDX_W-1:0];
	assign mathIdx   = mathRes.issueNo[ROB_IDX_W-1:0];
	assign memIdx    = memRes.issueNo[ROB_IDX_W-1:0];
	assign tailIdx   = tailNo[ROB_IDX_W-1:0];
	assign isMove    = issue.path == PATH_MOVE;
	assign doRelease = entFilled[tailIdx];

	// Counts the command still in the issue register
	assign robFull = (occupancy + ROB_CNT_W'(issue.valid)) >= ROB_CNT_W'(ROB_DEPTH);

	//////////////////////////////
	// Entry state and tail
	//////////////////////////////
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				entFilled[i] <= 1'b0;
			end
			tailNo    <= '0;
			occupancy <= '0;
			rsltValid <= 1'b0;
		end else begin
			rsltValid <= doRelease;
			if (doRelease) begin
				entFilled[tailIdx] <= 1'b0;
				tailNo             <= tailNo + issueNo_t'(1);
			end
			if (issue.valid) begin
				entFilled[allocIdx] <= isMove;         // A move is done on arrival
			end
			if (mathRes.valid) begin
				entFilled[mathIdx] <= 1'b1;
			end
			if (memRes.valid) begin
				entFilled[memIdx] <= 1'b1;
			end
			case ({issue.valid, doRelease})
				2'b10:   occupancy <= occupancy + ROB_CNT_W'(1);
				2'b01:   occupancy <= occupancy - ROB_CNT_W'(1);
				default: occupancy <= occupancy;
			endcase
		end
	end

	//////////////////////////////
	// Entry payload and output
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (issue.valid) begin
			entDst[allocIdx]   <= issue.dst;
			entData[allocIdx]  <= issue.opB;            // Kept only for a move
			entWrite[allocIdx] <= 1'b1;
		end
		if (mathRes.valid) begin
			entDst[mathIdx]   <= mathRes.dst;
			entData[mathIdx]  <= mathRes.data;
			entWrite[mathIdx] <= mathRes.write;
		end
		if (memRes.valid) begin
			entDst[memIdx]   <= memRes.dst;
			entData[memIdx]  <= memRes.data;
			entWrite[memIdx] <= memRes.write;
		end
		if (doRelease) begin
			rsltWrite   <= entWrite[tailIdx];
			rsltDst     <= entDst[tailIdx];
			rsltData    <= entData[tailIdx];
			rsltIssueNo <= tailNo;
		end
	end

endmodule

`default_nettype wire

// File: src/tpuPkg.sv
`default_nettype none

package tpuPkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int DATA_W     = 32;
	localparam int ISSUE_W    = 4;
	localparam int ROB_DEPTH  = 8;                  // Max commands in flight
	localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
	localparam int ROB_CNT_W  = ROB_IDX_W + 1;      // Holds 0 to ROB_DEPTH
	localparam int MATH_DEPTH = 3;
	localparam int DST_W      = 4;
	localparam int IMM_W      = 8;
	localparam int OFFSET_W   = 9;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [ISSUE_W-1:0] issueNo_t;          // Wraps around

	//////////////////////////////
	// Instruction word
	//////////////////////////////
	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		MUL   = 3'd2,
		MOV   = 3'd3,
		LOAD  = 3'd4,
		STORE = 3'd5
	} opcodeE;

	typedef enum logic [1:0] {
		PATH_MATH = 2'd0,
		PATH_MOVE = 2'd1,
		PATH_MEM  = 2'd2
	} pathE;

	typedef struct packed {
		opcodeE           opcode;
		logic [DST_W-1:0] dst;
		logic [IMM_W-1:0] imm;                      // Zero extended
		logic             useImm;                   // Imm replaces source two
	} aluFmtS;

	typedef struct packed {
		opcodeE              opcode;
		logic [DST_W-1:0]    dst;
		logic [OFFSET_W-1:0] offset;                // Sign extended, added to source one
	} memFmtS;

	typedef union packed {
		aluFmtS aluFmt;
		memFmtS memFmt;
	} instrWordU;

endpackage

`default_nettype wire
